//--- hdl/slot_bus_frame_pkg.sv
// Slot bus framing constants, raw shift word type and port index type
`default_nettype none

package slot_bus_frame_pkg;

    // Bits held by one external shift register
    localparam int unsigned WORD_WIDTH = 8;

    // Converter ports on the isolated 40-pin bus
    localparam int unsigned NUM_PORTS = 4;

    // Clock cycles per frame unless the top level overrides it
    // Must not be shorter than WORD_WIDTH or words get cut off
    localparam int unsigned DEFAULT_FRAME_LEN = 8;

    // Word as it sits in a shift register, MSB goes out first
    typedef logic [WORD_WIDTH-1:0] shift_word_t;

    // Port number, 0 to NUM_PORTS-1
    typedef logic [$clog2(NUM_PORTS)-1:0] port_index_t;

endpackage

`default_nettype wire

//--- hdl/slot_bus_status_pkg.sv
// Packed types for the port masks, port status, ADC overflow and hardware configuration words
`default_nettype none

package slot_bus_status_pkg;

    // One bit per converter port, bit 0 is port 0
    typedef logic [slot_bus_frame_pkg::NUM_PORTS-1:0] port_mask_t;

    // Content of the direction/channel-count status word
    typedef struct packed {
        // 1 means an 8-channel converter, 0 a 2-channel one
        port_mask_t num_channels;
        // 1 means ADC, 0 means DAC
        port_mask_t direction;
    } port_status_t;

    // Overflow flags of parallel ADCs
    // Order from MSB down is R3, L3, R2, L2, R1, L1, R0, L0
    typedef logic [2*slot_bus_frame_pkg::NUM_PORTS-1:0] adc_overflow_t;

    // Hardware configuration pins of one port
    typedef logic [slot_bus_frame_pkg::WORD_WIDTH-1:0] hwcon_t;

    // All ports' configuration words, port 0 in the low byte
    typedef hwcon_t [slot_bus_frame_pkg::NUM_PORTS-1:0] hwcon_set_t;

endpackage

`default_nettype wire

//--- hdl/frame_timer.sv
// frame_timer: frame cycle counter, registered frame_sync strobe and hwcon port index
`default_nettype none

module frame_timer #(
    parameter int unsigned FRAME_LEN = slot_bus_frame_pkg::DEFAULT_FRAME_LEN
) (
    input  logic                            custom_srclk,
    input  logic                            reset,
    output logic                            frame_sync,
    output slot_bus_frame_pkg::port_index_t hwcon_index
);

    localparam int unsigned CNT_W = $clog2(FRAME_LEN);
    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(FRAME_LEN - 1);

    logic [CNT_W-1:0] cycle_count;
    logic             last_cycle;

    assign last_cycle = (cycle_count == LAST_CYCLE);

    // Position inside the current frame
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            cycle_count <= '0;
        end else if (last_cycle) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Strobe is high on the cycle after the last count of a frame
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            frame_sync <= 1'b0;
        end else begin
            frame_sync <= last_cycle;
        end
    end

    // Next port's hwcon word, stepped once per frame
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            hwcon_index <= '0;
        end else if (frame_sync) begin
            hwcon_index <= hwcon_index + 1'b1;
        end
    end

    a_sync_single_cycle: assert property (
        @(posedge custom_srclk) disable iff (reset) frame_sync |=> !frame_sync);

    a_index_steps_on_sync: assert property (
        @(posedge custom_srclk) disable iff (reset) !frame_sync |=> $stable(hwcon_index));

endmodule

`default_nettype wire

//--- hdl/word_serializer.sv
// word_serializer: parallel load at frame_sync, MSB-first shift out with zero fill
`default_nettype none

module word_serializer #(
    parameter type payload_t = slot_bus_frame_pkg::shift_word_t
) (
    input  logic     custom_srclk,
    input  logic     reset,
    input  logic     frame_sync,
    input  payload_t word,
    output logic     serial
);

    localparam int unsigned W = slot_bus_frame_pkg::WORD_WIDTH;

    slot_bus_frame_pkg::shift_word_t shift_reg;

    // Load on the frame strobe, otherwise shift towards the MSB
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else if (frame_sync) begin
            shift_reg <= slot_bus_frame_pkg::shift_word_t'(word);
        end else begin
            // Zeros follow the last data bit until the next load
            shift_reg <= {shift_reg[W-2:0], 1'b0};
        end
    end

    // MSB drives the pin right after the load edge
    assign serial = shift_reg[W-1];

    a_word_known_at_load: assert property (
        @(posedge custom_srclk) disable iff (reset) frame_sync |-> !$isunknown(word));

endmodule

`default_nettype wire

//--- hdl/word_deserializer.sv
// word_deserializer: MSB-first shift in every cycle, typed word presented at frame_sync
`default_nettype none

module word_deserializer #(
    parameter type payload_t = slot_bus_frame_pkg::shift_word_t
) (
    input  logic     custom_srclk,
    input  logic     reset,
    input  logic     frame_sync,
    input  logic     serial,
    output payload_t word
);

    localparam int unsigned W = slot_bus_frame_pkg::WORD_WIDTH;

    slot_bus_frame_pkg::shift_word_t shift_reg;
    slot_bus_frame_pkg::shift_word_t next_word;

    // Newest sample enters at the LSB, oldest ends up at the MSB
    assign next_word = {shift_reg[W-2:0], serial};

    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= next_word;
        end
    end

    // The bit sampled on the strobe edge itself belongs to the word
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (frame_sync) begin
            word <= payload_t'(next_word);
        end
    end

endmodule

`default_nettype wire

//--- hdl/hwcon_sequencer.sv
// hwcon_sequencer: per-frame selection of one port's hwcon word and its serializer
`default_nettype none

module hwcon_sequencer (
    input  logic                            custom_srclk,
    input  logic                            reset,
    input  logic                            frame_sync,
    input  slot_bus_frame_pkg::port_index_t hwcon_index,
    input  slot_bus_status_pkg::hwcon_set_t hwcons,
    output logic                            serial
);

    slot_bus_status_pkg::hwcon_t hwcon_word;

    // Index still holds the old value on the load edge,
    // so port 0 goes out in the first frame after reset
    assign hwcon_word = hwcons[hwcon_index];

    word_serializer #(
        .payload_t (slot_bus_status_pkg::hwcon_t)
    ) u_hwcon_ser (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .word         (hwcon_word),
        .serial       (serial)
    );

endmodule

`default_nettype wire

//--- hdl/slot_bus_ctrl.sv
// slot_bus_ctrl: slot bus control path top level with frame timer, serializers and deserializers
`default_nettype none

module slot_bus_ctrl #(
    parameter int unsigned FRAME_LEN = slot_bus_frame_pkg::DEFAULT_FRAME_LEN
) (
    input  logic                              custom_srclk,
    input  logic                              reset,
    input  slot_bus_status_pkg::port_mask_t   adc_select,
    input  slot_bus_status_pkg::port_mask_t   dac_select,
    input  slot_bus_status_pkg::port_mask_t   clock_select,
    input  slot_bus_status_pkg::hwcon_set_t   hwcons,
    input  logic                              adc_ovf_serial,
    input  logic                              dirchan_serial,
    output logic                              spi_adc_cs,
    output logic                              spi_dac_cs,
    output logic                              custom_clksel,
    output logic                              custom_hwcon,
    output logic                              frame_sync,
    output slot_bus_status_pkg::adc_overflow_t adc_overflow,
    output slot_bus_status_pkg::port_status_t  port_status
);

    localparam int unsigned PAD_W =
        slot_bus_frame_pkg::WORD_WIDTH - slot_bus_frame_pkg::NUM_PORTS;

    slot_bus_frame_pkg::port_index_t hwcon_index;
    slot_bus_frame_pkg::shift_word_t adc_cs_word;
    slot_bus_frame_pkg::shift_word_t dac_cs_word;
    slot_bus_frame_pkg::shift_word_t clksel_word;

    // Chip selects are active low on the board, unused upper bits stay zero
    assign adc_cs_word = {{PAD_W{1'b0}}, ~adc_select};
    assign dac_cs_word = {{PAD_W{1'b0}}, ~dac_select};
    // 1 picks the 24.576 MHz clock for that port
    assign clksel_word = {{PAD_W{1'b0}}, clock_select};

    frame_timer #(
        .FRAME_LEN (FRAME_LEN)
    ) u_frame_timer (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .hwcon_index  (hwcon_index)
    );

    word_serializer u_adc_cs_ser (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .word         (adc_cs_word),
        .serial       (spi_adc_cs)
    );

    word_serializer u_dac_cs_ser (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .word         (dac_cs_word),
        .serial       (spi_dac_cs)
    );

    word_serializer u_clksel_ser (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .word         (clksel_word),
        .serial       (custom_clksel)
    );

    hwcon_sequencer u_hwcon_seq (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .hwcon_index  (hwcon_index),
        .hwcons       (hwcons),
        .serial       (custom_hwcon)
    );

    // Status words land one frame after they are shifted in
    word_deserializer #(
        .payload_t (slot_bus_status_pkg::adc_overflow_t)
    ) u_ovf_deser (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .serial       (adc_ovf_serial),
        .word         (adc_overflow)
    );

    word_deserializer #(
        .payload_t (slot_bus_status_pkg::port_status_t)
    ) u_dirchan_deser (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .frame_sync   (frame_sync),
        .serial       (dirchan_serial),
        .word         (port_status)
    );

endmodule

`default_nettype wire

//--- dv/slot_bus_ctrl_tb.sv
// slot_bus_ctrl_tb: clock, reset, xorshift stimulus, frame reference model, checks and watchdog
`default_nettype none

module slot_bus_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_LEN    = 8;
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_FRAMES   = 40;
    // Test frames plus reset and the first partial frame, with a few frames of slack
    localparam int TIMEOUT_NS   = (NUM_FRAMES + 4) * FRAME_LEN * 2 * HALF_PERIOD;

    logic custom_srclk = 1'b0;
    logic reset        = 1'b1;

    slot_bus_status_pkg::port_mask_t    adc_select     = '0;
    slot_bus_status_pkg::port_mask_t    dac_select     = '0;
    slot_bus_status_pkg::port_mask_t    clock_select   = '0;
    slot_bus_status_pkg::hwcon_set_t    hwcons         = '0;
    logic                               adc_ovf_serial = 1'b0;
    logic                               dirchan_serial = 1'b0;

    logic                               spi_adc_cs;
    logic                               spi_dac_cs;
    logic                               custom_clksel;
    logic                               custom_hwcon;
    logic                               frame_sync;
    slot_bus_status_pkg::adc_overflow_t adc_overflow;
    slot_bus_status_pkg::port_status_t  port_status;

    // Stimulus state
    logic [31:0] rng_state   = 32'd5;
    logic [31:0] rand_ctrl   = '0;
    logic [31:0] rand_status = '0;
    logic [31:0] rand_hwcon  = '0;
    int          reset_count = 0;
    int          edge_num    = 0;

    // Status words in flight and what is left of them to shift out
    slot_bus_frame_pkg::shift_word_t ovf_word     = '0;
    slot_bus_frame_pkg::shift_word_t dirchan_word = '0;
    slot_bus_frame_pkg::shift_word_t ovf_tx       = '0;
    slot_bus_frame_pkg::shift_word_t dirchan_tx   = '0;

    // Reference model state
    logic                               exp_sync         = 1'b0;
    int                                 bit_pos          = 8;
    int                                 frames_done      = 0;
    slot_bus_frame_pkg::port_index_t    hw_port          = '0;
    slot_bus_frame_pkg::shift_word_t    cap_adc_cs       = '0;
    slot_bus_frame_pkg::shift_word_t    cap_dac_cs       = '0;
    slot_bus_frame_pkg::shift_word_t    cap_clksel       = '0;
    slot_bus_frame_pkg::shift_word_t    cap_hwcon        = '0;
    slot_bus_status_pkg::adc_overflow_t exp_adc_overflow = '0;
    slot_bus_status_pkg::port_status_t  exp_port_status  = '0;

    slot_bus_ctrl #(
        .FRAME_LEN (FRAME_LEN)
    ) u_dut (
        .custom_srclk   (custom_srclk),
        .reset          (reset),
        .adc_select     (adc_select),
        .dac_select     (dac_select),
        .clock_select   (clock_select),
        .hwcons         (hwcons),
        .adc_ovf_serial (adc_ovf_serial),
        .dirchan_serial (dirchan_serial),
        .spi_adc_cs     (spi_adc_cs),
        .spi_dac_cs     (spi_dac_cs),
        .custom_clksel  (custom_clksel),
        .custom_hwcon   (custom_hwcon),
        .frame_sync     (frame_sync),
        .adc_overflow   (adc_overflow),
        .port_status    (port_status)
    );

    always #HALF_PERIOD custom_srclk = ~custom_srclk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Bit on the pin pos cycles after a load, zero once the word is gone
    function automatic logic expected_bit(input slot_bus_frame_pkg::shift_word_t word,
                                          input int pos);
        if (pos >= 8) begin
            return 1'b0;
        end
        return word[3'(7 - pos)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s (frame %0d): expected 0x%0h, actual 0x%0h",
                     name, frames_done, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One rising edge of the frame rules, using the inputs as they were before it
    task automatic update_model();
        if (exp_sync) begin
            cap_adc_cs       = {4'b0000, ~adc_select};
            cap_dac_cs       = {4'b0000, ~dac_select};
            cap_clksel       = {4'b0000, clock_select};
            cap_hwcon        = hwcons[hw_port];
            hw_port          = hw_port + 1'b1;
            bit_pos          = 0;
            exp_adc_overflow = ovf_word;
            exp_port_status  = dirchan_word;
            frames_done      = frames_done + 1;
        end else if (bit_pos < 8) begin
            bit_pos = bit_pos + 1;
        end
        // Strobe follows every FRAME_LEN-th edge after reset release
        exp_sync = (edge_num % FRAME_LEN == 0);
    endtask

    always @(posedge custom_srclk) begin
        if (reset) begin
            reset_count = reset_count + 1;
            if (reset_count == RESET_CYCLES) begin
                reset <= 1'b0;
            end
        end else begin
            edge_num = edge_num + 1;
            update_model();
            // New frame of stimulus on the strobe edge, and on the first edge after reset
            if ((edge_num - 1) % FRAME_LEN == 0) begin
                rand_ctrl    = next_rand();
                rand_status  = next_rand();
                rand_hwcon   = next_rand();
                adc_select   <= rand_ctrl[3:0];
                dac_select   <= rand_ctrl[7:4];
                clock_select <= rand_ctrl[11:8];
                hwcons       <= rand_hwcon;
                ovf_word     = rand_status[7:0];
                dirchan_word = rand_status[15:8];
                ovf_tx       = ovf_word;
                dirchan_tx   = dirchan_word;
            end
            // MSB first, sampled by the DUT on the next edge
            adc_ovf_serial <= ovf_tx[7];
            dirchan_serial <= dirchan_tx[7];
            ovf_tx         = {ovf_tx[6:0], 1'b0};
            dirchan_tx     = {dirchan_tx[6:0], 1'b0};
        end
    end

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge custom_srclk) begin
        check_value("frame_sync", 32'(exp_sync), 32'(frame_sync));
        check_value("spi_adc_cs", 32'(expected_bit(cap_adc_cs, bit_pos)), 32'(spi_adc_cs));
        check_value("spi_dac_cs", 32'(expected_bit(cap_dac_cs, bit_pos)), 32'(spi_dac_cs));
        check_value("custom_clksel", 32'(expected_bit(cap_clksel, bit_pos)),
                    32'(custom_clksel));
        check_value("custom_hwcon", 32'(expected_bit(cap_hwcon, bit_pos)),
                    32'(custom_hwcon));
        check_value("adc_overflow", 32'(exp_adc_overflow), 32'(adc_overflow));
        check_value("port_status", 32'(exp_port_status), 32'(port_status));
    end

    initial begin
        wait (frames_done >= NUM_FRAMES);
        // Last frame's falling-edge checks run before this edge
        @(posedge custom_srclk);
        $display("Test OK");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

//--- slot_bus_ctrl.f
hdl/slot_bus_frame_pkg.sv
hdl/slot_bus_status_pkg.sv
hdl/frame_timer.sv
hdl/word_serializer.sv
hdl/word_deserializer.sv
hdl/hwcon_sequencer.sv
hdl/slot_bus_ctrl.sv
dv/slot_bus_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the slot bus control path testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module slot_bus_ctrl_tb \
		--Mdir obj_dir -o Vslot_bus_ctrl_tb -f slot_bus_ctrl.f
	./obj_dir/Vslot_bus_ctrl_tb

clean:
	rm -rf obj_dir
